//--- verilog/mul_defines.svh
`ifndef MUL_DEFINES_SVH
`define MUL_DEFINES_SVH

`define MUL_OPERAND_WIDTH 8
`define MUL_NIBBLE_WIDTH  4
`define MUL_PARTIAL_WIDTH 12   // holds 15 * 255
`define MUL_PRODUCT_WIDTH 16

`define AXIL_ADDR_WIDTH   4
`define AXIL_DATA_WIDTH   32

`define MUL_REG_OPERANDS  4'h0   // {b, a} in bits 15:0
`define MUL_REG_PRODUCT   4'h4   // read only

`endif

//--- verilog/mul_pkg.sv
`include "mul_defines.svh"

package mul_pkg;

    typedef logic [`MUL_OPERAND_WIDTH-1:0]   operand_t;
    typedef logic [`MUL_NIBBLE_WIDTH-1:0]    nibble_t;
    typedef logic [`MUL_PARTIAL_WIDTH-1:0]   partial_t;
    typedef logic [`MUL_PRODUCT_WIDTH-1:0]   product_t;
    typedef logic [`AXIL_ADDR_WIDTH-1:0]     axil_addr_t;
    typedef logic [`AXIL_DATA_WIDTH-1:0]     axil_data_t;
    typedef logic [`AXIL_DATA_WIDTH/8-1:0]   axil_strb_t;

    typedef enum logic [1:0] {
        OKAY   = 2'b00,
        SLVERR = 2'b10
    } axil_resp_t;

    typedef struct packed {
        logic       awvalid;
        axil_addr_t awaddr;
        logic       wvalid;
        axil_data_t wdata;
        axil_strb_t wstrb;
        logic       bready;
        logic       arvalid;
        axil_addr_t araddr;
        logic       rready;
    } axil_req_t;

    typedef struct packed {
        logic       awready;
        logic       wready;
        logic       bvalid;
        axil_resp_t bresp;
        logic       arready;
        logic       rvalid;
        axil_data_t rdata;
        axil_resp_t rresp;
    } axil_rsp_t;

    typedef enum logic {WR_IDLE, WR_RESP} wr_state_t;
    typedef enum logic {RD_IDLE, RD_DATA} rd_state_t;

endpackage

//--- verilog/kogge_stone_adder.sv
module kogge_stone_adder #(
    parameter int WIDTH = 16
) (
    input  logic [WIDTH-1:0] in1,
    input  logic [WIDTH-1:0] in2,
    output logic [WIDTH-1:0] sum,
    output logic             cout
);

    localparam int LEVELS = $clog2(WIDTH);

    logic [WIDTH-1:0] g0;      // bitwise generate
    logic [WIDTH-1:0] p0;      // bitwise propagate, reused for the sum
    logic [WIDTH-1:0] g_top;   // group generate down to bit 0
    logic [WIDTH-1:0] carry;

    assign g0 = in1 & in2;
    assign p0 = in1 ^ in2;

    for (genvar lvl = 0; lvl < LEVELS; lvl++) begin : g_level
        localparam int DIST = 1 << lvl;
        logic [WIDTH-1:0] g_in;
        logic [WIDTH-1:0] p_in;
        logic [WIDTH-1:0] g_out;
        logic [WIDTH-1:0] p_out;

        if (lvl == 0) begin : g_first
            assign g_in = g0;
            assign p_in = p0;
        end else begin : g_next
            assign g_in = g_level[lvl-1].g_out;
            assign p_in = g_level[lvl-1].p_out;
        end

        for (genvar i = 0; i < WIDTH; i++) begin : g_bit
            if (i < DIST) begin : g_pass
                assign g_out[i] = g_in[i];   // already complete
                assign p_out[i] = p_in[i];
            end else if (i < 2 * DIST) begin : g_gray
                // span now reaches bit 0, so only generate matters
                assign g_out[i] = g_in[i] | (p_in[i] & g_in[i-DIST]);
                assign p_out[i] = p_in[i];
            end else begin : g_black
                assign g_out[i] = g_in[i] | (p_in[i] & g_in[i-DIST]);
                assign p_out[i] = p_in[i] & p_in[i-DIST];
            end
        end
    end

    assign g_top = g_level[LEVELS-1].g_out;

    // carry into bit i is the prefix generate of bits i-1:0
    assign carry = {g_top[WIDTH-2:0], 1'b0};
    assign sum   = p0 ^ carry;
    assign cout  = g_top[WIDTH-1];

endmodule

//--- verilog/nibble_product_reducer.sv
`include "mul_defines.svh"

module nibble_product_reducer (
    input  mul_pkg::nibble_t  multiplier,
    input  mul_pkg::operand_t multiplicand,
    output mul_pkg::partial_t partial
);

    import mul_pkg::*;

    partial_t rows [`MUL_NIBBLE_WIDTH];   // gated, shifted copies of b
    partial_t sum1;
    partial_t carry1;
    partial_t carry1_sh;
    partial_t sum2;
    partial_t carry2;
    partial_t carry2_sh;

    for (genvar k = 0; k < `MUL_NIBBLE_WIDTH; k++) begin : g_row
        assign rows[k] = multiplier[k] ? (partial_t'(multiplicand) << k) : '0;
    end

    // first 3:2 level over rows 0..2
    assign sum1      = rows[0] ^ rows[1] ^ rows[2];
    assign carry1    = (rows[0] & rows[1]) | (rows[0] & rows[2]) | (rows[1] & rows[2]);
    assign carry1_sh = carry1 << 1;

    // second level folds in row 3
    assign sum2      = sum1 ^ carry1_sh ^ rows[3];
    assign carry2    = (sum1 & carry1_sh) | (sum1 & rows[3]) | (carry1_sh & rows[3]);
    assign carry2_sh = carry2 << 1;

    // 15 * 255 fits in 12 bits, no carry out
    kogge_stone_adder #(
        .WIDTH (`MUL_PARTIAL_WIDTH)
    ) u_final (
        .in1  (sum2),
        .in2  (carry2_sh),
        .sum  (partial),
        .cout ()
    );

endmodule

//--- verilog/axil_mul_regs.sv
`include "mul_defines.svh"

module axil_mul_regs (
    input  logic               clk,
    input  logic               rst_n,
    input  mul_pkg::axil_req_t axil_req,
    output mul_pkg::axil_rsp_t axil_rsp,
    input  mul_pkg::product_t  product,
    output mul_pkg::operand_t  operand_a,
    output mul_pkg::operand_t  operand_b
);

    import mul_pkg::*;

    wr_state_t  wr_state;
    rd_state_t  rd_state;
    axil_resp_t bresp;
    axil_resp_t rresp;
    axil_data_t rdata;
    axil_data_t rd_value;    // decoded read data
    axil_resp_t rd_status;
    logic       wr_fire;     // aw and w accepted this cycle
    logic       rd_fire;
    logic       wr_hit;

    assign wr_fire = (wr_state == WR_IDLE) && axil_req.awvalid && axil_req.wvalid;
    assign rd_fire = (rd_state == RD_IDLE) && axil_req.arvalid;
    assign wr_hit  = (axil_req.awaddr == `MUL_REG_OPERANDS);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_state <= WR_IDLE;
        end else begin
            case (wr_state)
                WR_IDLE: begin
                    if (wr_fire) begin
                        wr_state <= WR_RESP;
                    end
                end
                WR_RESP: begin
                    if (axil_req.bready) begin
                        wr_state <= WR_IDLE;
                    end
                end
                default: wr_state <= WR_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            operand_a <= '0;
            operand_b <= '0;
        end else if (wr_fire && wr_hit) begin
            if (axil_req.wstrb[0]) begin
                operand_a <= axil_req.wdata[`MUL_OPERAND_WIDTH-1:0];
            end
            if (axil_req.wstrb[1]) begin
                operand_b <= axil_req.wdata[2*`MUL_OPERAND_WIDTH-1:`MUL_OPERAND_WIDTH];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (wr_fire) begin
            bresp <= wr_hit ? OKAY : SLVERR;
        end
    end

    always_comb begin
        rd_value  = '0;
        rd_status = OKAY;
        case (axil_req.araddr)
            `MUL_REG_OPERANDS: rd_value = axil_data_t'({operand_b, operand_a});
            `MUL_REG_PRODUCT:  rd_value = axil_data_t'(product);
            default:           rd_status = SLVERR;   // data stays zero
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rd_state <= RD_IDLE;
        end else begin
            case (rd_state)
                RD_IDLE: begin
                    if (rd_fire) begin
                        rd_state <= RD_DATA;
                    end
                end
                RD_DATA: begin
                    if (axil_req.rready) begin
                        rd_state <= RD_IDLE;
                    end
                end
                default: rd_state <= RD_IDLE;
            endcase
        end
    end

    // product sampled as it stands at the ar handshake
    always_ff @(posedge clk) begin
        if (rd_fire) begin
            rdata <= rd_value;
            rresp <= rd_status;
        end
    end

    always_comb begin
        axil_rsp.awready = wr_fire;
        axil_rsp.wready  = wr_fire;
        axil_rsp.bvalid  = (wr_state == WR_RESP);
        axil_rsp.bresp   = bresp;
        axil_rsp.arready = (rd_state == RD_IDLE);
        axil_rsp.rvalid  = (rd_state == RD_DATA);
        axil_rsp.rdata   = rdata;
        axil_rsp.rresp   = rresp;
    end

    a_bresp_held: assert property (@(posedge clk) disable iff (!rst_n)
        axil_rsp.bvalid && !axil_req.bready |=> axil_rsp.bvalid && $stable(axil_rsp.bresp));

    a_rdata_held: assert property (@(posedge clk) disable iff (!rst_n)
        axil_rsp.rvalid && !axil_req.rready |=> axil_rsp.rvalid && $stable(axil_rsp.rdata));

    a_no_write_in_resp: assert property (@(posedge clk) disable iff (!rst_n)
        wr_state == WR_RESP |-> !axil_rsp.awready && !axil_rsp.wready);

endmodule

//--- verilog/mul_axil_top.sv
`include "mul_defines.svh"

module mul_axil_top (
    input  logic               clk,
    input  logic               rst_n,
    input  mul_pkg::axil_req_t axil_req,
    output mul_pkg::axil_rsp_t axil_rsp
);

    import mul_pkg::*;

    operand_t operand_a;
    operand_t operand_b;
    partial_t partial_lo;   // a[3:0] * b
    partial_t partial_hi;   // a[7:4] * b
    product_t addend_lo;
    product_t addend_hi;
    product_t product;

    axil_mul_regs u_regs (
        .clk       (clk),
        .rst_n     (rst_n),
        .axil_req  (axil_req),
        .axil_rsp  (axil_rsp),
        .product   (product),
        .operand_a (operand_a),
        .operand_b (operand_b)
    );

    nibble_product_reducer reducer_lo (
        .multiplier   (operand_a[`MUL_NIBBLE_WIDTH-1:0]),
        .multiplicand (operand_b),
        .partial      (partial_lo)
    );

    nibble_product_reducer reducer_hi (
        .multiplier   (operand_a[`MUL_OPERAND_WIDTH-1:`MUL_NIBBLE_WIDTH]),
        .multiplicand (operand_b),
        .partial      (partial_hi)
    );

    assign addend_lo = product_t'(partial_lo);
    assign addend_hi = {partial_hi, {`MUL_NIBBLE_WIDTH{1'b0}}};   // weight 16

    // 255 * 255 fits in 16 bits
    kogge_stone_adder #(
        .WIDTH (`MUL_PRODUCT_WIDTH)
    ) u_combine (
        .in1  (addend_lo),
        .in2  (addend_hi),
        .sum  (product),
        .cout ()
    );

endmodule

//--- verification/tb_mul_axil.sv
`include "mul_defines.svh"

module tb_mul_axil;

    import mul_pkg::*;

    localparam int wait_limit = 20;   // cycles per handshake wait

    logic        clk = 1'b0;
    logic        rst_n;
    axil_req_t   axil_req;
    axil_rsp_t   axil_rsp;
    logic [31:0] lcg_state = 32'h6e84_a067;
    logic [31:0] rnd;
    operand_t    exp_a = '0;   // operand register model
    operand_t    exp_b = '0;
    axil_resp_t  exp_bresp = OKAY;
    axil_resp_t  exp_rresp = OKAY;
    axil_data_t  exp_rdata = '0;
    operand_t    dir_a [6] = '{8'd0, 8'd255, 8'd1, 8'd128, 8'd15, 8'd240};
    operand_t    dir_b [6] = '{8'd0, 8'd255, 8'd173, 8'd2, 8'd16, 8'd240};

    always #4 clk = ~clk;

    mul_axil_top UUT (
        .clk      (clk),
        .rst_n    (rst_n),
        .axil_req (axil_req),
        .axil_rsp (axil_rsp)
    );

    function automatic logic [31:0] next_random();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    task automatic abort_run(input string line);
        $display("%s", line);
        $display("Something failed");
        $fatal(1);
    endtask

    function automatic logic rsp_flag(input string name);
        if (name == "awready") return axil_rsp.awready;
        if (name == "bvalid") return axil_rsp.bvalid;
        if (name == "arready") return axil_rsp.arready;
        return axil_rsp.rvalid;
    endfunction

    task automatic wait_for(input string name);
        int n;
        n = 0;
        do begin
            @(negedge clk);   // outputs settled mid cycle
            n++;
            if (n > wait_limit) begin
                abort_run({"timed out waiting for ", name});
            end
        end while (!rsp_flag(name));
    endtask

    task automatic release_response(input logic [2:0] stall, input logic write);
        if (stall != 0) begin
            @(posedge clk);
            if (write) begin
                axil_req.awvalid <= 1'b1;   // next request waits behind the held response
                axil_req.wvalid  <= 1'b1;
                axil_req.awaddr  <= 4'h8;   // decodes unlike the held one
            end else begin
                axil_req.arvalid <= 1'b1;
                axil_req.araddr  <= 4'h8;
            end
            repeat (stall - 1) @(posedge clk);
        end
        @(posedge clk);
        axil_req.bready <= write;
        axil_req.rready <= !write;
        @(posedge clk);   // response retires here
        axil_req.bready  <= 1'b0;
        axil_req.rready  <= 1'b0;
        axil_req.awvalid <= 1'b0;
        axil_req.wvalid  <= 1'b0;
        axil_req.arvalid <= 1'b0;
    endtask

    task automatic axil_write(input axil_addr_t addr, input axil_data_t data,
                              input axil_strb_t strb, input logic [2:0] stall);
        exp_bresp = (addr == `MUL_REG_OPERANDS) ? OKAY : SLVERR;
        if (addr == `MUL_REG_OPERANDS && strb[0]) begin
            exp_a = data[7:0];
        end
        if (addr == `MUL_REG_OPERANDS && strb[1]) begin
            exp_b = data[15:8];
        end
        @(posedge clk);
        axil_req.awvalid <= 1'b1;
        axil_req.awaddr  <= addr;
        axil_req.wvalid  <= 1'b1;
        axil_req.wdata   <= data;
        axil_req.wstrb   <= strb;
        wait_for("awready");
        @(posedge clk);   // handshake edge
        axil_req.awvalid <= 1'b0;
        axil_req.wvalid  <= 1'b0;
        wait_for("bvalid");
        release_response(stall, 1'b1);
    endtask

    task automatic axil_read(input axil_addr_t addr, input logic [2:0] stall);
        exp_rresp = OKAY;
        case (addr)
            `MUL_REG_OPERANDS: exp_rdata = {16'h0000, exp_b, exp_a};
            `MUL_REG_PRODUCT:  exp_rdata = axil_data_t'(exp_a) * axil_data_t'(exp_b);
            default: begin
                exp_rdata = '0;
                exp_rresp = SLVERR;
            end
        endcase
        @(posedge clk);
        axil_req.arvalid <= 1'b1;
        axil_req.araddr  <= addr;
        wait_for("arready");
        @(posedge clk);
        axil_req.arvalid <= 1'b0;
        wait_for("rvalid");
        release_response(stall, 1'b0);
    endtask

    task automatic read_both(input logic [2:0] stall);
        axil_read(`MUL_REG_PRODUCT, stall);
        axil_read(`MUL_REG_OPERANDS, stall);
    endtask

    a_bresp: assert property (@(posedge clk) disable iff (!rst_n)
        $rose(axil_rsp.bvalid) |-> axil_rsp.bresp == exp_bresp)
        else abort_run($sformatf("[ERROR] %0t bresp expected %0h actual %0h",
                                 $time, exp_bresp, axil_rsp.bresp));

    a_rresp: assert property (@(posedge clk) disable iff (!rst_n)
        $rose(axil_rsp.rvalid) |-> axil_rsp.rresp == exp_rresp)
        else abort_run($sformatf("[ERROR] %0t rresp expected %0h actual %0h",
                                 $time, exp_rresp, axil_rsp.rresp));

    a_rdata: assert property (@(posedge clk) disable iff (!rst_n)
        $rose(axil_rsp.rvalid) |-> axil_rsp.rdata == exp_rdata)
        else abort_run($sformatf("[ERROR] %0t rdata expected %0h actual %0h",
                                 $time, exp_rdata, axil_rsp.rdata));

    a_b_held: assert property (@(posedge clk) disable iff (!rst_n)
        axil_rsp.bvalid && !axil_req.bready |=> axil_rsp.bvalid && $stable(axil_rsp.bresp))
        else abort_run("write response dropped or changed while bready was low");

    a_r_held: assert property (@(posedge clk) disable iff (!rst_n)
        axil_rsp.rvalid && !axil_req.rready |=>
            axil_rsp.rvalid && $stable(axil_rsp.rdata) && $stable(axil_rsp.rresp))
        else abort_run("read response dropped or changed while rready was low");

    a_w_blocked: assert property (@(posedge clk) disable iff (!rst_n)
        axil_rsp.bvalid |-> !axil_rsp.awready && !axil_rsp.wready)
        else abort_run("write accepted while a write response was held");

    a_ar_blocked: assert property (@(posedge clk) disable iff (!rst_n)
        axil_rsp.rvalid |-> !axil_rsp.arready)
        else abort_run("read accepted while a read response was held");

    a_b_latency: assert property (@(posedge clk) disable iff (!rst_n)
        axil_rsp.awready && axil_rsp.wready |=> axil_rsp.bvalid)
        else abort_run("bvalid did not rise one cycle after the write handshake");

    a_r_latency: assert property (@(posedge clk) disable iff (!rst_n)
        axil_req.arvalid && axil_rsp.arready |=> axil_rsp.rvalid)
        else abort_run("rvalid did not rise one cycle after the read handshake");

    initial begin
        rst_n    <= 1'b0;
        axil_req <= '0;
        repeat (4) @(posedge clk);
        rst_n <= 1'b1;
        @(negedge clk);
        assert (!axil_rsp.bvalid && !axil_rsp.rvalid && axil_rsp.arready &&
                !axil_rsp.awready && !axil_rsp.wready)
            else abort_run("handshake outputs are wrong after reset");
        read_both(3'd0);

        for (int i = 0; i < 6; i++) begin
            axil_write(`MUL_REG_OPERANDS, {16'h0000, dir_b[i], dir_a[i]}, 4'hf, 3'd0);
            read_both(3'd0);
        end

        for (int i = 0; i < 200; i++) begin
            rnd = next_random();
            axil_write(`MUL_REG_OPERANDS, rnd, {rnd[25:24], 2'b11}, 3'd0);   // upper lanes unused
            read_both(3'd0);
        end

        // b lane alone, then a lane alone
        axil_write(`MUL_REG_OPERANDS, next_random(), 4'b0010, 3'd0);
        read_both(3'd0);
        axil_write(`MUL_REG_OPERANDS, next_random(), 4'b0001, 3'd0);
        read_both(3'd0);

        axil_write(`MUL_REG_PRODUCT, next_random(), 4'hf, 3'd0);
        read_both(3'd0);
        axil_write(4'h8, next_random(), 4'hf, 3'd0);
        read_both(3'd0);
        axil_read(4'h8, 3'd0);
        axil_read(4'hc, 3'd0);

        for (int i = 0; i < 40; i++) begin
            rnd = next_random();
            axil_write(`MUL_REG_OPERANDS, rnd, 4'hf, rnd[18:16]);
            axil_read(`MUL_REG_PRODUCT, rnd[21:19]);
            axil_read(`MUL_REG_OPERANDS, rnd[24:22]);
        end

        $display("Everything OK");
        $finish;
    end

endmodule

//--- sim.f
+incdir+verilog
verilog/mul_pkg.sv
verilog/kogge_stone_adder.sv
verilog/nibble_product_reducer.sv
verilog/axil_mul_regs.sv
verilog/mul_axil_top.sv
verification/tb_mul_axil.sv

//--- run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert \
    --top-module tb_mul_axil \
    -f sim.f \
    -o tb_mul_axil

./obj_dir/tb_mul_axil
